// File: Makefile
# Verilator flow for the sequential divider.

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_divider
RTL_TOP   ?= divider_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_TEXT ?= === PASS ===

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TB_TOP)

# The run passes only when the pass message shows up in the output.
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: div_controller.sv
`timescale 1ns/1ps

module div_controller (
    input  logic clk,
    input  logic rst,
    input  logic op_valid,
    output logic load,
    output logic step,
    output logic finish_valid
);

    div_ctrl_pkg::div_state_e state_q;
    div_ctrl_pkg::div_state_e state_d;
    div_ctrl_pkg::count_t     count_q;

    // ####################
    // Next state
    // ####################

    always_comb begin
        state_d = state_q;
        case (state_q)
            div_ctrl_pkg::IDLE: begin
                if (op_valid) begin
                    state_d = div_ctrl_pkg::LOAD;
                end
            end
            div_ctrl_pkg::LOAD: begin
                state_d = div_ctrl_pkg::ITERATE;
            end
            div_ctrl_pkg::ITERATE: begin
                // The last step is the one taken with the counter at one.
                if (count_q == div_ctrl_pkg::count_t'(1)) begin
                    state_d = div_ctrl_pkg::FINISH;
                end
            end
            div_ctrl_pkg::FINISH: begin
                state_d = div_ctrl_pkg::IDLE;
            end
            default: begin
                state_d = div_ctrl_pkg::IDLE;
            end
        endcase
    end

    // ####################
    // State and counter
    // ####################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= div_ctrl_pkg::IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == div_ctrl_pkg::LOAD) begin
                count_q <= div_ctrl_pkg::DIV_STEPS;
            end else if (state_q == div_ctrl_pkg::ITERATE) begin
                count_q <= div_ctrl_pkg::count_t'(count_q - 1'b1);
            end
        end
    end

    // Outputs are a registered decode of the state, so every strobe
    // trails its state by one cycle and stays free of glitches.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load         <= 1'b0;
            step         <= 1'b0;
            finish_valid <= 1'b0;
        end else begin
            load         <= (state_q == div_ctrl_pkg::LOAD);
            step         <= (state_q == div_ctrl_pkg::ITERATE);
            finish_valid <= (state_q == div_ctrl_pkg::FINISH);
        end
    end

endmodule

// File: div_ctrl_pkg.sv
package div_ctrl_pkg;

    // ####################
    // Controller encodings
    // ####################

    // States of the iteration controller.
    typedef enum logic [1:0] {
        IDLE,    // Waiting for registered operands.
        LOAD,    // Preset the datapath and the counter.
        ITERATE, // One restoring step per cycle.
        FINISH   // Results are final in the datapath.
    } div_state_e;

    // Wide enough to hold the full step count.
    typedef logic [5:0] count_t;

    // One restoring step per quotient bit.
    localparam count_t DIV_STEPS = count_t'(div_types_pkg::DIV_WIDTH);

endpackage

// File: div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  div_types_pkg::div_req_t  req,
    input  logic                     release_pulse,
    output logic                     busy,
    output logic                     op_valid,
    output div_types_pkg::word_t     abs_dividend,
    output div_types_pkg::word_t     abs_divisor,
    output div_types_pkg::div_sign_t sign
);

    localparam int MSB = div_types_pkg::DIV_WIDTH - 1;

    logic                 busy_q;
    logic                 accept;
    logic                 dividend_neg;
    logic                 divisor_neg;
    logic                 divisor_zero;
    div_types_pkg::word_t mag_dividend;
    div_types_pkg::word_t mag_divisor;

    // The response cycle already counts as free, so a new request
    // can be taken on the edge that closes it.
    assign busy   = busy_q & ~release_pulse;
    assign accept = req_valid & ~busy; // Strobes while busy are dropped.

    // Operand signs only matter for signed requests.
    assign dividend_neg = req.is_signed & req.dividend[MSB];
    assign divisor_neg  = req.is_signed & req.divisor[MSB];
    assign divisor_zero = (req.divisor == '0);

    // Magnitudes for the unsigned datapath. The most negative value maps onto itself,
    // which is still the right unsigned magnitude.
    assign mag_dividend = dividend_neg ? -req.dividend : req.dividend;
    assign mag_divisor  = divisor_neg ? -req.divisor : req.divisor;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q   <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept; // One-cycle strobe to the controller.
            if (accept) begin
                busy_q <= 1'b1;
            end else if (release_pulse) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Operand and sign registers hold for the whole division.
    always_ff @(posedge clk) begin
        if (accept) begin
            abs_dividend     <= mag_dividend;
            abs_divisor      <= mag_divisor;
            sign.quot_neg    <= (dividend_neg ^ divisor_neg) & ~divisor_zero;
            sign.rem_neg     <= dividend_neg;
            sign.div_by_zero <= divisor_zero;
        end
    end

endmodule

// File: div_restoring_datapath.sv
`timescale 1ns/1ps

module div_restoring_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 step,
    input  div_types_pkg::word_t dividend,
    input  div_types_pkg::word_t divisor,
    output div_types_pkg::word_t quotient,
    output div_types_pkg::word_t remainder
);

    localparam int W = div_types_pkg::DIV_WIDTH;

    // The accumulator lives in remainder and the dividend bits are shifted
    // out of the top of quotient while quotient bits enter at the bottom.

    logic [W:0]           shifted_acc; // Accumulator with the next dividend bit.
    logic [W+1:0]         trial;       // Trial difference with a borrow bit on top.
    logic                 trial_neg;
    div_types_pkg::word_t acc_next;
    div_types_pkg::word_t quo_next;

    // ####################
    // One restoring step
    // ####################

    // Shift the accumulator and quotient pair left by one bit.
    assign shifted_acc = {remainder, quotient[W-1]};

    // Subtract the divisor. The extra top bit turns into a borrow flag
    // when the shifted accumulator is smaller than the divisor.
    assign trial     = {1'b0, shifted_acc} - {2'b00, divisor};
    assign trial_neg = trial[W+1];

    // Restore on a negative difference, otherwise keep it.
    // Either value is below the divisor and fits one word.
    always_comb begin
        if (trial_neg) begin
            acc_next = shifted_acc[W-1:0];
        end else begin
            acc_next = trial[W-1:0];
        end
    end

    // The new quotient bit is one when the subtraction succeeded.
    assign quo_next = {quotient[W-2:0], ~trial_neg};

    // ####################
    // Registers
    // ####################

    // With a zero divisor every trial succeeds, so after all steps the
    // quotient is all ones and the accumulator holds the dividend magnitude.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (load) begin
            quotient  <= dividend; // Dividend bits shift out as quotient bits shift in.
            remainder <= '0;
        end else if (step) begin
            quotient  <= quo_next;
            remainder <= acc_next;
        end
    end

endmodule

// File: div_result_fixup.sv
`timescale 1ns/1ps

module div_result_fixup (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     finish_valid,
    input  div_types_pkg::word_t     quotient,
    input  div_types_pkg::word_t     remainder,
    input  div_types_pkg::div_sign_t sign,
    output logic                     rsp_valid,
    output div_types_pkg::div_rsp_t  rsp,
    output logic                     release_pulse
);

    div_types_pkg::word_t quot_signed;
    div_types_pkg::word_t rem_signed;
    div_types_pkg::word_t quot_fixed;
    div_types_pkg::word_t rem_fixed;

    // Apply the sign plan to the unsigned magnitudes.
    assign quot_signed = sign.quot_neg ? -quotient : quotient;
    assign rem_signed  = sign.rem_neg ? -remainder : remainder;

    // ####################
    // Divide by zero
    // ####################

    assign quot_fixed = sign.div_by_zero ? '1 : quot_signed;

    // On a zero divisor the datapath leaves the dividend magnitude in the
    // remainder, and rem_neg holds the dividend sign, so the rebuilt
    // value is the original dividend in both cases.
    assign rem_fixed = rem_signed;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= finish_valid; // One cycle per division.
        end
    end

    // The response holds until the next division finishes.
    always_ff @(posedge clk) begin
        if (finish_valid) begin
            rsp.quotient    <= quot_fixed;
            rsp.remainder   <= rem_fixed;
            rsp.div_by_zero <= sign.div_by_zero;
        end
    end

    assign release_pulse = rsp_valid; // Frees the operand stage with the response.

endmodule

// File: div_types_pkg.sv
package div_types_pkg;

    // ####################
    // Data widths
    // ####################

    localparam int DIV_WIDTH = 32; // Operand and result width in bits.

    // One data word as seen on the request and response ports.
    typedef logic [DIV_WIDTH-1:0] word_t;

    // ####################
    // Transaction structs
    // ####################

    // A division request as presented with the req_valid strobe.
    typedef struct packed {
        word_t dividend;
        word_t divisor;
        logic  is_signed; // Operands are two's complement when set.
    } div_req_t;

    // A finished division, held stable until the next response.
    typedef struct packed {
        word_t quotient;
        word_t remainder;
        logic  div_by_zero;
    } div_rsp_t;

    // Sign plan worked out at operand time and applied again at the end.
    typedef struct packed {
        logic quot_neg;    // Quotient must be negated.
        logic rem_neg;     // Remainder must be negated.
        logic div_by_zero; // Divisor was zero.
    } div_sign_t;

endpackage

// File: divider_top.sv
`timescale 1ns/1ps

module divider_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  div_types_pkg::div_req_t req,
    output logic                    busy,
    output logic                    rsp_valid,
    output div_types_pkg::div_rsp_t rsp
);

    // ####################
    // Internal wires
    // ####################

    logic                     op_valid;
    logic                     release_pulse;
    logic                     load;
    logic                     step;
    logic                     finish_valid;
    div_types_pkg::word_t     abs_dividend;
    div_types_pkg::word_t     abs_divisor;
    div_types_pkg::word_t     quot_mag;
    div_types_pkg::word_t     rem_mag;
    div_types_pkg::div_sign_t sign;

    // Takes the request, owns busy and forms the magnitudes.
    div_operand_prep u_prep (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .release_pulse (release_pulse),
        .busy          (busy),
        .op_valid      (op_valid),
        .abs_dividend  (abs_dividend),
        .abs_divisor   (abs_divisor),
        .sign          (sign)
    );

    div_controller u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .load         (load),
        .step         (step),
        .finish_valid (finish_valid)
    );

    div_restoring_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .dividend  (abs_dividend),
        .divisor   (abs_divisor),
        .quotient  (quot_mag),
        .remainder (rem_mag)
    );

    // Signs, divide by zero and the response register.
    div_result_fixup u_fixup (
        .clk           (clk),
        .rst           (rst),
        .finish_valid  (finish_valid),
        .quotient      (quot_mag),
        .remainder     (rem_mag),
        .sign          (sign),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .release_pulse (release_pulse)
    );

endmodule

// File: sources.f
div_types_pkg.sv
div_ctrl_pkg.sv
div_operand_prep.sv
div_controller.sv
div_restoring_datapath.sv
div_result_fixup.sv
divider_top.sv
tb_divider.sv

// File: tb_divider.sv
`timescale 1ns/1ps

module tb_divider;

    localparam int NUM_ROWS   = 19;
    localparam int NUM_RANDOM = 40;
    localparam int LATENCY    = div_types_pkg::DIV_WIDTH + 4; // Accepting edge to rsp_valid.
    localparam int WAIT_LIMIT = 100;                          // Cycles before a wait gives up.

    // One table row holds a request and the response it must produce.
    typedef struct packed {
        div_types_pkg::div_req_t req;
        div_types_pkg::div_rsp_t rsp;
    } vector_t;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    div_types_pkg::div_req_t req;
    logic                    busy;
    logic                    rsp_valid;
    div_types_pkg::div_rsp_t rsp;

    vector_t table_rows [NUM_ROWS];

    divider_top UUT (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ####################
    // Helpers
    // ####################

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic report_timeout(input string reason);
        $display("Timeout at %0t ns: %s", $time, reason);
        $display("=== FAIL ===");
        $fatal(1, "Stopped after a timeout.");
    endtask

    task automatic set_row(input int idx, input div_types_pkg::word_t dividend,
                           input div_types_pkg::word_t divisor, input logic is_signed,
                           input div_types_pkg::word_t quotient,
                           input div_types_pkg::word_t remainder, input logic div_by_zero);
        table_rows[idx].req.dividend    = dividend;
        table_rows[idx].req.divisor     = divisor;
        table_rows[idx].req.is_signed   = is_signed;
        table_rows[idx].rsp.quotient    = quotient;
        table_rows[idx].rsp.remainder   = remainder;
        table_rows[idx].rsp.div_by_zero = div_by_zero;
    endtask

    task automatic fill_table();
        // Unsigned rows.
        set_row(0, 32'h0000_0064, 32'h0000_0007, 1'b0, 32'h0000_000e, 32'h0000_0002, 1'b0);
        set_row(1, 32'h0000_0005, 32'h0000_0009, 1'b0, 32'h0000_0000, 32'h0000_0005, 1'b0);
        set_row(2, 32'hdead_beef, 32'h0000_0001, 1'b0, 32'hdead_beef, 32'h0000_0000, 1'b0);
        set_row(3, 32'hffff_ffff, 32'h0000_0010, 1'b0, 32'h0fff_ffff, 32'h0000_000f, 1'b0);
        set_row(4, 32'h8000_0000, 32'hffff_ffff, 1'b0, 32'h0000_0000, 32'h8000_0000, 1'b0);
        set_row(5, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 32'h0000_0001, 32'h0000_0000, 1'b0);
        set_row(6, 32'h0000_0000, 32'h0000_0005, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0);
        // Signed rows, all four sign pairs.
        set_row(7, 32'h0000_0007, 32'h0000_0002, 1'b1, 32'h0000_0003, 32'h0000_0001, 1'b0);
        set_row(8, 32'hffff_fff9, 32'h0000_0002, 1'b1, 32'hffff_fffd, 32'hffff_ffff, 1'b0);
        set_row(9, 32'h0000_0007, 32'hffff_fffe, 1'b1, 32'hffff_fffd, 32'h0000_0001, 1'b0);
        set_row(10, 32'hffff_fff9, 32'hffff_fffe, 1'b1, 32'h0000_0003, 32'hffff_ffff, 1'b0);
        set_row(11, 32'hffff_fffa, 32'h0000_0003, 1'b1, 32'hffff_fffe, 32'h0000_0000, 1'b0);
        set_row(12, 32'hffff_ffff, 32'h0000_0005, 1'b1, 32'h0000_0000, 32'hffff_ffff, 1'b0);
        set_row(13, 32'h7fff_ffff, 32'h8000_0000, 1'b1, 32'h0000_0000, 32'h7fff_ffff, 1'b0);
        // Overflow and the most negative dividend.
        set_row(14, 32'h8000_0000, 32'hffff_ffff, 1'b1, 32'h8000_0000, 32'h0000_0000, 1'b0);
        set_row(15, 32'h8000_0000, 32'h0000_0001, 1'b1, 32'h8000_0000, 32'h0000_0000, 1'b0);
        // Division by zero keeps the dividend as remainder.
        set_row(16, 32'h1234_5678, 32'h0000_0000, 1'b0, 32'hffff_ffff, 32'h1234_5678, 1'b1);
        set_row(17, 32'hffff_ff85, 32'h0000_0000, 1'b1, 32'hffff_ffff, 32'hffff_ff85, 1'b1);
        set_row(18, 32'h8000_0000, 32'h0000_0000, 1'b1, 32'hffff_ffff, 32'h8000_0000, 1'b1);
    endtask

    // Reference result built from the simulator's own division operators.
    function automatic div_types_pkg::div_rsp_t model_divide(input div_types_pkg::div_req_t r);
        div_types_pkg::div_rsp_t result;
        logic signed [31:0]      sa;
        logic signed [31:0]      sb;
        sa = r.dividend;
        sb = r.divisor;
        result.div_by_zero = (r.divisor == '0);
        if (result.div_by_zero) begin
            result.quotient  = '1;
            result.remainder = r.dividend;
        end else if (r.is_signed && r.dividend == 32'h8000_0000 && r.divisor == '1) begin
            result.quotient  = r.dividend; // Overflow wraps to the most negative value.
            result.remainder = '0;
        end else if (r.is_signed) begin
            result.quotient  = sa / sb; // Truncates toward zero.
            result.remainder = sa % sb; // Takes the sign of the dividend.
        end else begin
            result.quotient  = r.dividend / r.divisor;
            result.remainder = r.dividend % r.divisor;
        end
        return result;
    endfunction

    // ####################
    // Request and response
    // ####################

    // Strobes one request and checks busy, latency and the response. A second
    // strobe with the extra request goes out inject_at edges after acceptance.
    task automatic run_division(input div_types_pkg::div_req_t r,
                                input div_types_pkg::div_rsp_t expected, input int inject_at,
                                input div_types_pkg::div_req_t extra, input string label);
        int waited;
        int edges;
        waited = 0;
        edges  = -1; // The first rising edge is the accepting one.
        while (busy) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout($sformatf("%s: busy never dropped", label));
            end
        end
        req_valid = 1'b1;
        req       = r;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            req_valid = (edges == inject_at);
            if (edges == inject_at) begin
                req = extra;
            end
            if (!rsp_valid) begin
                check_value($sformatf("%s busy", label), 32'(busy), 32'd1);
                if (edges > WAIT_LIMIT) begin
                    report_timeout($sformatf("%s: no rsp_valid", label));
                end
            end
        end while (!rsp_valid);
        check_value($sformatf("%s latency", label), 32'(edges), 32'(LATENCY));
        check_value($sformatf("%s quotient", label), rsp.quotient, expected.quotient);
        check_value($sformatf("%s remainder", label), rsp.remainder, expected.remainder);
        check_value($sformatf("%s div_by_zero", label), 32'(rsp.div_by_zero),
                    32'(expected.div_by_zero));
    endtask

    // No response may appear while idle, and the last one must hold.
    task automatic check_quiet(input int cycles, input div_types_pkg::div_rsp_t held);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("rsp_valid while idle", 32'(rsp_valid), 32'd0);
            check_value("busy while idle", 32'(busy), 32'd0);
        end
        check_value("held quotient", rsp.quotient, held.quotient);
        check_value("held remainder", rsp.remainder, held.remainder);
    endtask

    // ####################
    // Test sequence
    // ####################

    initial begin
        div_types_pkg::div_req_t r;
        div_types_pkg::div_req_t second;
        int                      sel;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        void'($urandom(32'h8a1c));
        fill_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("busy after reset", 32'(busy), 32'd0);
        check_value("rsp_valid after reset", 32'(rsp_valid), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_division(table_rows[i].req, table_rows[i].rsp, -1, '0, $sformatf("row %0d", i));
        end

        // A strobe in the middle of a division must be dropped.
        r.dividend      = 32'd1000;
        r.divisor       = 32'd3;
        r.is_signed     = 1'b0;
        second.dividend = 32'd9;
        second.divisor  = 32'd4;
        second.is_signed = 1'b0;
        run_division(r, model_divide(r), 10, second, "overlap");
        check_quiet(LATENCY + 8, model_divide(r));

        for (int n = 0; n < NUM_RANDOM; n++) begin
            sel = int'($urandom % 8);
            r.dividend = $urandom;
            if ($urandom % 8 == 0) begin
                r.dividend = 32'h8000_0000;
            end
            if (sel == 0) begin
                r.divisor = '0;
            end else if (sel < 3) begin
                r.divisor = $urandom % 16; // Small divisors, zero included.
            end else if (sel == 3) begin
                r.divisor = '1;
            end else begin
                r.divisor = $urandom;
            end
            r.is_signed = 1'($urandom % 2);
            run_division(r, model_divide(r), -1, '0, $sformatf("random %0d", n));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
